// ==== hdl/sdBusPkg.sv ====
/* SD bus protocol constants and the command frame type.
   Shared by the command port, the DAT reader and the CRC engine. */
package sdBusPkg;

    // ==================================================
    // Frame and line geometry
    // ==================================================
    localparam int cmdFrameBits = 48;
    localparam int cmdCrcBits = 7;
    localparam int datCrcBits = 16;
    localparam int datLines = 4;

    // CRC generators, x^7 + x^3 + 1 and x^16 + x^12 + x^5 + 1
    localparam logic [cmdCrcBits-1:0] crc7Poly = 7'h09;
    localparam logic [datCrcBits-1:0] crc16Poly = 16'h1021;

    // ==================================================
    // Command indices
    // ==================================================
    // READ_MULTIPLE_BLOCK
    localparam logic [5:0] cmdIdxReadMulti = 6'd18;
    // STOP_TRANSMISSION
    localparam logic [5:0] cmdIdxStop = 6'd12;

    typedef logic [cmdCrcBits-1:0] crc7T;
    typedef logic [datCrcBits-1:0] crc16T;

    // Index and argument, the part of a CMD frame the host chooses
    typedef struct packed {
        logic [5:0]  idx;
        logic [31:0] arg;
    } sdCmdT;

endpackage

// ==== hdl/sdHostPkg.sv ====
/* Client-side word and address types plus the block geometry of the read core. */
package sdHostPkg;

    // ==================================================
    // Block geometry
    // ==================================================
    localparam int blockBytes = 512;
    localparam int wordBits = 16;
    localparam int wordsPerBlock = blockBytes * 8 / wordBits;

    // Four DAT lines deliver one nibble per clock
    localparam int nibblesPerWord = wordBits / 4;

    // ==================================================
    // Client types
    // ==================================================
    typedef logic [wordBits-1:0] dataWordT;
    typedef logic [31:0] blockAddrT;

endpackage

// ==== hdl/sdCrc.sv ====
/* Serial CRC shift register for the SD bus; the CRC type and polynomial pick CRC7 or CRC16. */
`timescale 1ns/1ns

module sdCrc #(
    parameter type crcT = sdBusPkg::crc7T,
    parameter crcT poly = sdBusPkg::crc7Poly
) (
    input  logic clk,
    input  logic arstN,
    input  logic clear,
    input  logic shiftEn,
    input  logic bitIn,
    output crcT  crc
);
    localparam int msb = $bits(crcT) - 1;

    crcT  base;
    logic feedback;

    // Clear and shift together start a fresh CRC with bitIn
    always_comb begin
        base = clear ? crcT'(0) : crc;
        feedback = bitIn ^ base[msb];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            crc <= '0;
        end else if (shiftEn) begin
            crc <= crcT'(base << 1) ^ (feedback ? poly : crcT'(0));
        end else begin
            crc <= base;
        end
    end

endmodule

// ==== hdl/sdCmdPort.sv ====
/* CMD line port: shifts out a 48-bit command with CRC7 and receives the R1 response.
   Pulses cmdSent after the frame and respDone, with respErr, after the response check. */
`timescale 1ns/1ns

module sdCmdPort (
    input  logic           clk,
    input  logic           arstN,
    input  logic           cmdStart,
    input  sdBusPkg::sdCmdT cmd,
    input  logic           sdCmdIn,
    output logic           sdCmdOut,
    output logic           sdCmdOutActive,
    output logic           cmdSent,
    output logic           respDone,
    output logic           respErr
);
    import sdBusPkg::*;

    localparam int cntW = $clog2(cmdFrameBits);

    typedef enum logic [1:0] {rxIdle, rxWait, rxRecv, rxCheck} rxStateT;

    // Transmit side
    logic [cmdFrameBits-1:0] txReg;
    logic [cntW-1:0]         txCnt;
    logic                    txCrcPhase;
    logic [2:0]              txCrcSel;
    crc7T                    txCrc;

    // Receive side
    rxStateT                 rxState;
    logic                    rxStage;
    logic [cmdFrameBits-1:0] rxReg;
    logic [cntW-1:0]         rxCnt;
    logic                    rxCrcEn;
    crc7T                    rxCrc;

    // ==================================================
    // Transmit
    // ==================================================
    // txCnt is the frame bit now on the line, 47 down to 0
    assign txCrcPhase = (txCnt <= cntW'(cmdCrcBits)) && (txCnt != '0);
    assign txCrcSel = 3'(txCnt - 1'b1);

    // CRC bits are spliced in from the live CRC, the frame holds zeros there
    assign sdCmdOut = !sdCmdOutActive ? 1'b1 :
                      txCrcPhase ? txCrc[txCrcSel] : txReg[cmdFrameBits-1];

    sdCrc #(.crcT(crc7T), .poly(crc7Poly)) txCrc_i (
        .clk    (clk),
        .arstN  (arstN),
        .clear  (cmdStart),
        .shiftEn(sdCmdOutActive && (txCnt > cntW'(cmdCrcBits))),
        .bitIn  (txReg[cmdFrameBits-1]),
        .crc    (txCrc)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sdCmdOutActive <= 1'b0;
            txCnt <= '0;
            cmdSent <= 1'b0;
        end else begin
            cmdSent <= 1'b0;
            if (cmdStart) begin
                sdCmdOutActive <= 1'b1;
                txCnt <= cntW'(cmdFrameBits - 1);
            end else if (sdCmdOutActive) begin
                txCnt <= txCnt - 1'b1;
                if (txCnt == '0) begin
                    sdCmdOutActive <= 1'b0;
                    cmdSent <= 1'b1;
                end
            end
        end
    end

    // Start bit, direction bit, index, argument, CRC slot, end bit
    always_ff @(posedge clk) begin
        if (cmdStart) begin
            txReg <= {2'b01, cmd, crc7T'(0), 1'b1};
        end else if (sdCmdOutActive) begin
            txReg <= txReg << 1;
        end
    end

    // ==================================================
    // Receive
    // ==================================================
    // rxCnt is the index of the response bit being shifted in
    assign rxCrcEn = ((rxState == rxWait) && !rxStage) ||
                     ((rxState == rxRecv) && (rxCnt > cntW'(cmdCrcBits)));

    sdCrc #(.crcT(crc7T), .poly(crc7Poly)) rxCrc_i (
        .clk    (clk),
        .arstN  (arstN),
        .clear  (rxState == rxWait),
        .shiftEn(rxCrcEn),
        .bitIn  (rxStage),
        .crc    (rxCrc)
    );

    assign respDone = (rxState == rxCheck);
    // CRC7, transmission bit and stop bit
    assign respErr = respDone && ((rxReg[cmdCrcBits:1] != rxCrc) ||
                                  rxReg[cmdFrameBits-2] || !rxReg[0]);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxState <= rxIdle;
            rxStage <= 1'b1;
            rxCnt <= '0;
        end else begin
            // Own frame is masked so the receiver only sees the card
            rxStage <= sdCmdOutActive ? 1'b1 : sdCmdIn;
            case (rxState)
                rxIdle: begin
                    if (sdCmdOutActive && (txCnt == '0)) begin
                        rxState <= rxWait;
                    end
                end
                rxWait: begin
                    if (!rxStage) begin
                        rxState <= rxRecv;
                        rxCnt <= cntW'(cmdFrameBits - 2);
                    end
                end
                rxRecv: begin
                    rxCnt <= rxCnt - 1'b1;
                    if (rxCnt == '0) begin
                        rxState <= rxCheck;
                    end
                end
                default: begin
                    rxState <= rxIdle;
                end
            endcase
            if (cmdStart) begin
                rxState <= rxIdle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((rxState == rxWait) || (rxState == rxRecv)) begin
            rxReg <= {rxReg[cmdFrameBits-2:0], rxStage};
        end
    end

endmodule

// ==== hdl/sdDatReader.sv ====
/* DAT receiver for one 512-byte block: finds the start bit, packs nibbles into words,
   then checks the per-line CRC16 and the end nibble. Armed by a blockArm pulse. */
`timescale 1ns/1ns

module sdDatReader (
    input  logic                clk,
    input  logic                arstN,
    input  logic                blockArm,
    input  logic [3:0]          sdDatIn,
    output sdHostPkg::dataWordT word,
    output logic                wordValid,
    output logic                blockDone,
    output logic                blockErr
);
    import sdBusPkg::*;
    import sdHostPkg::*;

    localparam int dataNibbles = wordsPerBlock * nibblesPerWord;
    localparam int cntW = $clog2(dataNibbles);
    localparam int nibSelW = $clog2(nibblesPerWord);

    typedef enum logic [2:0] {dIdle, dWait, dData, dCrc, dEnd} datStateT;

    datStateT         state;
    logic [3:0]       datStage;
    logic [cntW-1:0]  nibCnt;
    logic             lineErr;
    logic             crcMiss;
    logic             wordLast;
    logic [3:0]       crcBitSel;
    dataWordT         packReg;
    dataWordT         packNext;
    crc16T            lineCrc [datLines];

    // ==================================================
    // Per-line CRC16
    // ==================================================
    for (genvar i = 0; i < datLines; i++) begin : gLineCrc
        sdCrc #(.crcT(crc16T), .poly(crc16Poly)) crc_i (
            .clk    (clk),
            .arstN  (arstN),
            .clear  (blockArm),
            .shiftEn(state == dData),
            .bitIn  (datStage[i]),
            .crc    (lineCrc[i])
        );
    end

    // Received CRC arrives MSB first, one bit per line per cycle
    assign crcBitSel = 4'(datCrcBits - 1) - nibCnt[3:0];

    always_comb begin
        crcMiss = 1'b0;
        for (int i = 0; i < datLines; i++) begin
            if (lineCrc[i][crcBitSel] != datStage[i]) begin
                crcMiss = 1'b1;
            end
        end
    end

    // ==================================================
    // Block sequencing
    // ==================================================
    assign wordLast = (state == dData) && (nibCnt[nibSelW-1:0] == '1);
    // First nibble ends up in the top of the word
    assign packNext = {packReg[wordBits-datLines-1:0], datStage};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= dIdle;
            datStage <= '1;
            nibCnt <= '0;
            lineErr <= 1'b0;
            wordValid <= 1'b0;
            blockDone <= 1'b0;
            blockErr <= 1'b0;
        end else begin
            datStage <= sdDatIn;
            wordValid <= wordLast;
            blockDone <= 1'b0;
            blockErr <= 1'b0;
            case (state)
                dIdle: begin
                    if (blockArm) begin
                        state <= dWait;
                    end
                end
                // DAT0 low marks the start bit
                dWait: begin
                    if (!datStage[0]) begin
                        state <= dData;
                        nibCnt <= '0;
                        lineErr <= 1'b0;
                    end
                end
                dData: begin
                    nibCnt <= nibCnt + 1'b1;
                    if (nibCnt == '1) begin
                        state <= dCrc;
                    end
                end
                dCrc: begin
                    lineErr <= lineErr | crcMiss;
                    nibCnt <= nibCnt + 1'b1;
                    if (nibCnt[3:0] == 4'hf) begin
                        state <= dEnd;
                    end
                end
                dEnd: begin
                    blockDone <= 1'b1;
                    blockErr <= lineErr || (datStage != 4'hf);
                    state <= dIdle;
                end
                default: begin
                    state <= dIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dData) begin
            packReg <= packNext;
        end
        if (wordLast) begin
            word <= packNext;
        end
    end

endmodule

// ==== hdl/sdReadCore.sv ====
/* Top of the SD read core: read sequencer for CMD18 and CMD12, sticky error flag,
   and the CMD and DAT ports. Clients hold reqTrigger high to keep blocks streaming. */
`timescale 1ns/1ns

module sdReadCore (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 reqTrigger,
    input  sdHostPkg::blockAddrT reqAddr,
    output logic                 reqAccepted,
    output sdHostPkg::dataWordT  dataOut,
    output logic                 dataOutValid,
    output logic                 err,
    input  logic                 sdCmdIn,
    output logic                 sdCmdOut,
    output logic                 sdCmdOutActive,
    input  logic [3:0]           sdDatIn
);
    import sdBusPkg::*;
    import sdHostPkg::*;

    typedef enum logic [2:0] {
        sIdle, sSendRead, sWaitSent, sArm, sBlock, sSendStop, sStopResp, sBusy
    } seqStateT;

    seqStateT  state;
    blockAddrT addrQ;
    sdCmdT     cmd;
    logic      cmdStart;
    logic      cmdSent;
    logic      respDone;
    logic      respErr;
    logic      blockArm;
    logic      blockDone;
    logic      blockErr;
    logic      respSeen;
    logic      blockSeen;
    logic      blockEnd;
    logic      dat0Q;

    // ==================================================
    // Command and block control
    // ==================================================
    assign cmdStart = (state == sSendRead) || (state == sSendStop);
    assign blockArm = (state == sArm);
    // CMD18 response only matters for the first block, later it stays seen
    assign blockEnd = (respSeen || respDone) && (blockSeen || blockDone);

    always_comb begin
        cmd = '{idx: cmdIdxReadMulti, arg: addrQ};
        if (state == sSendStop) begin
            cmd = '{idx: cmdIdxStop, arg: 32'h0};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
            reqAccepted <= 1'b0;
            respSeen <= 1'b0;
            blockSeen <= 1'b0;
            err <= 1'b0;
            dat0Q <= 1'b1;
        end else begin
            reqAccepted <= 1'b0;
            dat0Q <= sdDatIn[0];
            err <= err | respErr | blockErr;
            if (respDone) begin
                respSeen <= 1'b1;
            end
            if (blockDone) begin
                blockSeen <= 1'b1;
            end
            case (state)
                sIdle: begin
                    if (reqTrigger) begin
                        reqAccepted <= 1'b1;
                        state <= sSendRead;
                    end
                end
                sSendRead: begin
                    respSeen <= 1'b0;
                    state <= sWaitSent;
                end
                // Data may start before the response ends, so arm right away
                sWaitSent: begin
                    if (cmdSent) begin
                        state <= sArm;
                    end
                end
                sArm: begin
                    blockSeen <= 1'b0;
                    state <= sBlock;
                end
                sBlock: begin
                    if (blockEnd) begin
                        if (reqTrigger) begin
                            reqAccepted <= 1'b1;
                            state <= sArm;
                        end else begin
                            state <= sSendStop;
                        end
                    end
                end
                sSendStop: begin
                    state <= sStopResp;
                end
                sStopResp: begin
                    if (respDone) begin
                        state <= sBusy;
                    end
                end
                // Card holds DAT0 low while busy
                sBusy: begin
                    if (dat0Q) begin
                        state <= sIdle;
                    end
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == sIdle) && reqTrigger) begin
            addrQ <= reqAddr;
        end
    end

    // ==================================================
    // Ports
    // ==================================================
    sdCmdPort cmdPort_i (
        .clk           (clk),
        .arstN         (arstN),
        .cmdStart      (cmdStart),
        .cmd           (cmd),
        .sdCmdIn       (sdCmdIn),
        .sdCmdOut      (sdCmdOut),
        .sdCmdOutActive(sdCmdOutActive),
        .cmdSent       (cmdSent),
        .respDone      (respDone),
        .respErr       (respErr)
    );

    sdDatReader datReader_i (
        .clk      (clk),
        .arstN    (arstN),
        .blockArm (blockArm),
        .sdDatIn  (sdDatIn),
        .word     (dataOut),
        .wordValid(dataOutValid),
        .blockDone(blockDone),
        .blockErr (blockErr)
    );

endmodule

// ==== verification/sdCardModel.sv ====
/* Behavioral SD card for the read core testbench: answers CMD18 and CMD12 with R1,
   streams LFSR data blocks, and injects response CRC, data CRC and busy faults. */
`timescale 1ns/1ns

module sdCardModel (
    input  logic       clk,
    input  logic       sdCmdOut,
    input  logic       sdCmdOutActive,
    input  logic       corruptRespCrc,
    input  int         corruptDatLine,
    input  int         busyLen,
    output logic       sdCmdIn,
    output logic [3:0] sdDatIn
);
    import sdBusPkg::*;

    // Logs read by the testbench
    logic [47:0] frameLog[$];
    logic [3:0]  sentNibbles[$];
    int          stopsDone;
    time         busyEndTime;

    logic [31:0] lfsr;
    logic [3:0]  streamDat;
    logic        busyHold;
    event        startStream;

    // Busy only pulls DAT0 low
    assign sdDatIn = busyHold ? 4'he : streamDat;

    // Galois LFSR, one step per data bit
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic crc7T crc7Of(input logic [39:0] bits);
        crc7T c;
        logic fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic crc16T crc16Step(input crc16T c, input logic b);
        logic fb;
        fb = b ^ c[15];
        return {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    endfunction

    task automatic driveDat(input logic [3:0] v);
        @(posedge clk);
        #1 streamDat = v;
    endtask

    // Sample mid-cycle while the host drives CMD
    task automatic captureFrame(output logic [47:0] f);
        f = '0;
        do begin
            @(negedge clk);
        end while (!sdCmdOutActive);
        for (int i = 0; i < cmdFrameBits; i++) begin
            f = {f[46:0], sdCmdOut};
            @(negedge clk);
        end
    endtask

    task automatic sendResponse(input logic [5:0] idx);
        logic [47:0] r;
        crc7T c;
        r = {2'b00, idx, 32'h0000_0900, 7'h00, 1'b1};
        c = crc7Of(r[47:8]);
        if (corruptRespCrc) begin
            c[0] = ~c[0];
        end
        r[7:1] = c;
        repeat (4) @(posedge clk);
        for (int i = cmdFrameBits - 1; i >= 0; i--) begin
            @(posedge clk);
            #1 sdCmdIn = r[i];
        end
        @(posedge clk);
        #1 sdCmdIn = 1'b1;
    endtask

    task automatic sendBlock();
        crc16T crc [4];
        logic [3:0] nib;
        for (int i = 0; i < 4; i++) begin
            crc[i] = '0;
        end
        repeat (8) driveDat(4'hf);
        driveDat(4'h0);
        for (int n = 0; n < 1024; n++) begin
            // First LFSR bit goes to DAT3
            for (int b = 3; b >= 0; b--) begin
                lfsr = lfsrStep(lfsr);
                nib[b] = lfsr[0];
            end
            sentNibbles.push_back(nib);
            for (int i = 0; i < 4; i++) begin
                crc[i] = crc16Step(crc[i], nib[i]);
            end
            driveDat(nib);
        end
        for (int i = 0; i < 4; i++) begin
            if (i == corruptDatLine) begin
                crc[i][0] = ~crc[i][0];
            end
        end
        for (int k = 15; k >= 0; k--) begin
            driveDat({crc[3][k], crc[2][k], crc[1][k], crc[0][k]});
        end
        driveDat(4'hf);
    endtask

    // ==================================================
    // Command handling
    // ==================================================
    initial begin
        logic [47:0] f;
        sdCmdIn = 1'b1;
        streamDat = 4'hf;
        busyHold = 1'b0;
        stopsDone = 0;
        busyEndTime = 0;
        lfsr = 32'h083854d2;
        forever begin
            captureFrame(f);
            frameLog.push_back(f);
            if (f[45:40] == cmdIdxStop) begin
                busyHold = (busyLen > 0);
                sendResponse(f[45:40]);
                repeat (busyLen) @(posedge clk);
                #1 busyHold = 1'b0;
                busyEndTime = $time;
                stopsDone++;
            end else begin
                -> startStream;
                sendResponse(f[45:40]);
            end
        end
    end

    // Blocks keep coming until the host starts a command between blocks
    initial begin
        logic stop;
        forever begin
            @(startStream);
            stop = 1'b0;
            while (!stop) begin
                sendBlock();
                for (int i = 0; i < 10; i++) begin
                    @(negedge clk);
                    if (sdCmdOutActive) begin
                        stop = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== verification/sdReadCore_sva.sv ====
/* Concurrent checks on the SD read core pins, attached to every sdReadCore by bind. */
`timescale 1ns/1ns

module sdReadCore_sva (
    input logic clk,
    input logic arstN,
    input logic sdCmdOutActive,
    input logic err,
    input logic reqAccepted
);
    logic [7:0] activeLen;

    // Length of the current CMD drive window
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            activeLen <= '0;
        end else begin
            activeLen <= sdCmdOutActive ? activeLen + 8'd1 : 8'd0;
        end
    end

    frameLength: assert property (@(posedge clk) disable iff (!arstN)
        $fell(sdCmdOutActive) |-> (activeLen == 8'd48))
        else $error("CMD output active for %0d cycles instead of 48", activeLen);

    errSticky: assert property (@(posedge clk) disable iff (!arstN) err |=> err)
        else $error("err fell without a reset");

    acceptPulse: assert property (@(posedge clk) disable iff (!arstN)
        reqAccepted |=> !reqAccepted)
        else $error("reqAccepted high for two cycles in a row");

endmodule

bind sdReadCore sdReadCore_sva sva_i (
    .clk           (clk),
    .arstN         (arstN),
    .sdCmdOutActive(sdCmdOutActive),
    .err           (err),
    .reqAccepted   (reqAccepted)
);

// ==== verification/sdReadCoreTb.sv ====
/* Testbench for the SD read core: clock and reset generator plus directed tests
   against the behavioral card. */
`timescale 1ns/1ns

module sdTbClock (
    output logic clk,
    output logic arstN
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 arstN = 1'b1;
    end

    task automatic pulseReset();
        @(posedge clk);
        #1 arstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 arstN = 1'b1;
    endtask

endmodule

module sdReadCoreTb;
    import sdBusPkg::*;
    import sdHostPkg::*;

    localparam int waitLimit = 20000;

    logic       clk;
    logic       arstN;
    logic       reqTrigger;
    blockAddrT  reqAddr;
    logic       reqAccepted;
    dataWordT   dataOut;
    logic       dataOutValid;
    logic       err;
    logic       sdCmdIn;
    logic       sdCmdOut;
    logic       sdCmdOutActive;
    logic [3:0] sdDatIn;
    logic       corruptRespCrc;
    int         corruptDatLine;
    int         busyLen;
    int         errCount;
    int         checkCount;
    int         testCount;
    int         testErrStart;
    dataWordT   gotWords[$];
    time        acceptTimes[$];

    sdTbClock clkGen_i (.clk(clk), .arstN(arstN));

    sdReadCore dut_i (
        .clk           (clk),
        .arstN         (arstN),
        .reqTrigger    (reqTrigger),
        .reqAddr       (reqAddr),
        .reqAccepted   (reqAccepted),
        .dataOut       (dataOut),
        .dataOutValid  (dataOutValid),
        .err           (err),
        .sdCmdIn       (sdCmdIn),
        .sdCmdOut      (sdCmdOut),
        .sdCmdOutActive(sdCmdOutActive),
        .sdDatIn       (sdDatIn)
    );

    sdCardModel card_i (
        .clk           (clk),
        .sdCmdOut      (sdCmdOut),
        .sdCmdOutActive(sdCmdOutActive),
        .corruptRespCrc(corruptRespCrc),
        .corruptDatLine(corruptDatLine),
        .busyLen       (busyLen),
        .sdCmdIn       (sdCmdIn),
        .sdDatIn       (sdDatIn)
    );

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arstN && dataOutValid) begin
            gotWords.push_back(dataOut);
        end
        if (arstN && reqAccepted) begin
            acceptTimes.push_back($time);
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic abortRun(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    function automatic crc7T crc7Of(input logic [39:0] bits);
        crc7T c;
        logic fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic waitAccepts(input int n);
        int cycles;
        cycles = 0;
        while (acceptTimes.size() < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun("reqAccepted");
            end
        end
    endtask

    task automatic waitFrames(input int n);
        int cycles;
        cycles = 0;
        while (card_i.frameLog.size() < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun("a CMD frame");
            end
        end
    endtask

    task automatic waitStops(input int n);
        int cycles;
        cycles = 0;
        while (card_i.stopsDone < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun("the end of the stop sequence");
            end
        end
        // Response check and the DAT0 input stage
        repeat (8) @(posedge clk);
    endtask

    task automatic clearLogs();
        gotWords.delete();
        acceptTimes.delete();
        card_i.frameLog.delete();
        card_i.sentNibbles.delete();
    endtask

    task automatic checkFrame(input int k, input logic [5:0] idx, input logic [31:0] arg);
        logic [47:0] exp;
        exp = {2'b01, idx, arg, crc7Of({2'b01, idx, arg}), 1'b1};
        if (card_i.frameLog.size() <= k) begin
            errCount++;
            $display("CMD frame %0d was never sent", k);
        end else begin
            checkEq($sformatf("CMD frame %0d", k), card_i.frameLog[k], exp);
        end
    endtask

    // Four nibbles per word, first nibble on top
    task automatic checkWords(input int blocks);
        dataWordT exp;
        checkEq("word count", gotWords.size(), blocks * wordsPerBlock);
        for (int i = 0; i < gotWords.size(); i++) begin
            if (4 * i + 3 < card_i.sentNibbles.size()) begin
                exp = {card_i.sentNibbles[4 * i], card_i.sentNibbles[4 * i + 1],
                       card_i.sentNibbles[4 * i + 2], card_i.sentNibbles[4 * i + 3]};
                checkEq($sformatf("dataOut[%0d]", i), gotWords[i], exp);
            end
        end
    endtask

    task automatic runRequest(input blockAddrT addr, input int blocks);
        int stopsBefore;
        stopsBefore = card_i.stopsDone;
        @(posedge clk);
        #1 reqAddr = addr;
        reqTrigger = 1'b1;
        waitAccepts(blocks);
        @(posedge clk);
        #1 reqTrigger = 1'b0;
        waitStops(stopsBefore + 1);
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("%s finished with %0d errors", name, errCount - testErrStart);
        testErrStart = errCount;
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic testSingleBlock();
        clearLogs();
        runRequest(32'h0000_1234, 1);
        checkFrame(0, cmdIdxReadMulti, 32'h0000_1234);
        checkFrame(1, cmdIdxStop, 32'h0);
        checkEq("frame count", card_i.frameLog.size(), 2);
        checkWords(1);
        checkEq("err", err, 1'b0);
        endTest("singleBlock");
    endtask

    task automatic testMultiBlock();
        clearLogs();
        runRequest(32'h0001_0040, 3);
        checkFrame(0, cmdIdxReadMulti, 32'h0001_0040);
        checkFrame(1, cmdIdxStop, 32'h0);
        checkEq("accept count", acceptTimes.size(), 3);
        checkWords(3);
        checkEq("err", err, 1'b0);
        endTest("multiBlock");
    endtask

    task automatic testDatCrcFault();
        clkGen_i.pulseReset();
        clearLogs();
        corruptDatLine = 2;
        runRequest(32'h0000_0800, 1);
        checkEq("err", err, 1'b1);
        repeat (20) @(posedge clk);
        checkEq("err held", err, 1'b1);
        corruptDatLine = -1;
        endTest("datCrcFault");
    endtask

    task automatic testRespCrcFault();
        clkGen_i.pulseReset();
        clearLogs();
        checkEq("err after reset", err, 1'b0);
        corruptRespCrc = 1'b1;
        runRequest(32'h0000_0900, 1);
        checkEq("err", err, 1'b1);
        corruptRespCrc = 1'b0;
        endTest("respCrcFault");
    endtask

    task automatic testBusyAfterStop();
        int stopsBefore;
        clkGen_i.pulseReset();
        clearLogs();
        stopsBefore = card_i.stopsDone;
        busyLen = 60;
        @(posedge clk);
        #1 reqAddr = 32'h0000_0a00;
        reqTrigger = 1'b1;
        waitAccepts(1);
        @(posedge clk);
        #1 reqTrigger = 1'b0;
        waitFrames(2);
        // New request while the card is still busy
        @(posedge clk);
        #1 reqAddr = 32'h0000_0b00;
        reqTrigger = 1'b1;
        waitAccepts(2);
        // Busy release time of the first stop is only known once it is over
        waitStops(stopsBefore + 1);
        checkEq("accept after busy", acceptTimes[1] > card_i.busyEndTime, 1'b1);
        @(posedge clk);
        #1 reqTrigger = 1'b0;
        busyLen = 4;
        waitStops(stopsBefore + 2);
        checkFrame(2, cmdIdxReadMulti, 32'h0000_0b00);
        checkFrame(3, cmdIdxStop, 32'h0);
        endTest("busyAfterStop");
    endtask

    initial begin
        int cycles;
        reqTrigger = 1'b0;
        reqAddr = '0;
        corruptRespCrc = 1'b0;
        corruptDatLine = -1;
        busyLen = 4;
        errCount = 0;
        checkCount = 0;
        testCount = 0;
        testErrStart = 0;
        cycles = 0;
        while (arstN !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 100) begin
                abortRun("reset release");
            end
        end
        testSingleBlock();
        testMultiBlock();
        testDatCrcFault();
        testRespCrcFault();
        testBusyAfterStop();
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sdReadCore.f ====
hdl/sdBusPkg.sv
hdl/sdHostPkg.sv
hdl/sdCrc.sv
hdl/sdCmdPort.sv
hdl/sdDatReader.sv
hdl/sdReadCore.sv
verification/sdCardModel.sv
verification/sdReadCore_sva.sv
verification/sdReadCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SD read core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sdReadCoreTb \
    -f sdReadCore.f -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
